// File: include/stopwatch_macros.svh
`ifndef STOPWATCH_MACROS_SVH
`define STOPWATCH_MACROS_SVH

// Clock cycles per counted second, kept small for simulation
`define STOPWATCH_TICK_DIV 4

// Clock cycles each display digit stays lit
`define STOPWATCH_SCAN_DIV 2

// Flip-flops in each input synchronizer
`define STOPWATCH_SYNC_STAGES 2

`endif

// File: logic/stopwatch_pkg.sv
`default_nettype none

package stopwatch_pkg;

    // Mode codes
    typedef enum logic [1:0] {
        MODE_SETTING = 2'b00,
        MODE_PAUSED  = 2'b01,
        MODE_RUNNING = 2'b10,
        MODE_STOPPED = 2'b11
    } mode_t;

    // One decimal digit, 0 to 9
    typedef logic [3:0] bcd_t;

endpackage

`default_nettype wire

// File: logic/time_if.sv
`timescale 1ns/1ps
`default_nettype none

interface time_if;
    import stopwatch_pkg::*;

    bcd_t min_tens;
    bcd_t min_ones;
    bcd_t sec_tens;
    bcd_t sec_ones;

    modport producer (
        output min_tens,
        output min_ones,
        output sec_tens,
        output sec_ones
    );

    modport consumer (
        input min_tens,
        input min_ones,
        input sec_tens,
        input sec_ones
    );

endinterface

`default_nettype wire

// File: logic/button_conditioner.sv
`timescale 1ns/1ps
`default_nettype none
`include "stopwatch_macros.svh"

module button_conditioner #(
    parameter int SYNC_STAGES = `STOPWATCH_SYNC_STAGES
) (
    input  logic clk,
    input  logic rst_n,
    input  logic hour_set,
    input  logic pb_stop,
    input  logic pb_pause,
    output logic hour_set_level,
    output logic stop_press,
    output logic pause_press
);

    // Bit 2 hour_set, bit 1 pb_stop, bit 0 pb_pause
    logic [SYNC_STAGES-1:0][2:0] sync_q;
    logic [2:0] synced;
    logic [1:0] btn_prev;

    assign synced = sync_q[SYNC_STAGES-1];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync_q <= '0;
        end
        else
        begin
            sync_q[0] <= {hour_set, pb_stop, pb_pause};
            for (int i = 1; i < SYNC_STAGES; i++)
            begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // Level goes through the same output register so all three line up
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            btn_prev       <= 2'b00;
            hour_set_level <= 1'b0;
            stop_press     <= 1'b0;
            pause_press    <= 1'b0;
        end
        else
        begin
            btn_prev       <= synced[1:0];
            hour_set_level <= synced[2];
            stop_press     <= synced[1] & ~btn_prev[1];
            pause_press    <= synced[0] & ~btn_prev[0];
        end
    end

    a_stop_single: assert property (@(posedge clk) disable iff (!rst_n)
        stop_press |=> !stop_press);

    a_pause_single: assert property (@(posedge clk) disable iff (!rst_n)
        pause_press |=> !pause_press);

endmodule

`default_nettype wire

// File: logic/mode_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mode_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hour_set_level,
    input  logic                stop_press,
    input  logic                pause_press,
    output stopwatch_pkg::mode_t mode
);
    import stopwatch_pkg::*;

    mode_t state;
    mode_t next_state;

    // hour_set wins over both buttons, stop wins over pause
    always_comb
    begin
        next_state = state;
        if (hour_set_level)
        begin
            next_state = MODE_SETTING;
        end
        else
        begin
            case (state)
                MODE_SETTING:
                begin
                    // Switch dropped, hold the set time
                    next_state = MODE_PAUSED;
                end
                MODE_PAUSED:
                begin
                    if (stop_press)
                    begin
                        next_state = MODE_STOPPED;
                    end
                    else if (pause_press)
                    begin
                        next_state = MODE_RUNNING;
                    end
                end
                MODE_RUNNING:
                begin
                    if (stop_press)
                    begin
                        next_state = MODE_STOPPED;
                    end
                    else if (pause_press)
                    begin
                        next_state = MODE_PAUSED;
                    end
                end
                MODE_STOPPED:
                begin
                    // Pause is ignored here
                    if (stop_press)
                    begin
                        next_state = MODE_RUNNING;
                    end
                end
                default:
                begin
                    next_state = MODE_STOPPED;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= MODE_STOPPED;
        end
        else
        begin
            state <= next_state;
        end
    end

    assign mode = state;

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(state) &&
        (state inside {MODE_SETTING, MODE_PAUSED, MODE_RUNNING, MODE_STOPPED}));

endmodule

`default_nettype wire

// File: logic/time_counter.sv
`timescale 1ns/1ps
`default_nettype none
`include "stopwatch_macros.svh"

module time_counter #(
    parameter int TICK_DIV = `STOPWATCH_TICK_DIV
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  stopwatch_pkg::mode_t mode,
    time_if.producer             time_bus
);
    import stopwatch_pkg::*;

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CNT_W-1:0] PRESC_LAST = CNT_W'(TICK_DIV - 1);

    logic [CNT_W-1:0] presc;
    logic [CNT_W-1:0] presc_eff;
    mode_t            mode_q;
    logic             counting;
    logic             tick;

    bcd_t min_tens;
    bcd_t min_ones;
    bcd_t sec_tens;
    bcd_t sec_ones;
    logic [7:0] sec_next;
    logic [7:0] min_next;

    // Next value of a 00..59 BCD pair, as {tens, ones}
    function automatic logic [7:0] bcd60_inc(input bcd_t tens, input bcd_t ones);
        logic [7:0] res;
        if (ones != 4'd9)
            res = {tens, ones + 4'd1};
        else if (tens != 4'd5)
            res = {tens + 4'd1, 4'd0};
        else
            res = 8'h00;
        return res;
    endfunction

    assign counting = (mode == MODE_RUNNING) || (mode == MODE_SETTING);

    // A fresh mode starts the second from zero
    assign presc_eff = (mode != mode_q) ? '0 : presc;
    assign tick      = counting && (presc_eff == PRESC_LAST);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            presc  <= '0;
            mode_q <= MODE_STOPPED;
        end
        else
        begin
            mode_q <= mode;
            if (!counting || tick)
                presc <= '0;
            else
                presc <= presc_eff + 1'b1;
        end
    end

    assign sec_next = bcd60_inc(sec_tens, sec_ones);
    assign min_next = bcd60_inc(min_tens, min_ones);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            {min_tens, min_ones, sec_tens, sec_ones} <= 16'h0000;
        end
        else if (mode == MODE_STOPPED)
        begin
            {min_tens, min_ones, sec_tens, sec_ones} <= 16'h0000;
        end
        else if (tick && mode == MODE_SETTING)
        begin
            {min_tens, min_ones} <= min_next;
        end
        else if (tick)
        begin
            {sec_tens, sec_ones} <= sec_next;
            // 59 seconds rolls into the minutes, 59:59 wraps to 00:00
            if (sec_next == 8'h00)
                {min_tens, min_ones} <= min_next;
        end
    end

    assign time_bus.min_tens = min_tens;
    assign time_bus.min_ones = min_ones;
    assign time_bus.sec_tens = sec_tens;
    assign time_bus.sec_ones = sec_ones;

    a_digits_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        time_bus.sec_ones <= 4'd9 && time_bus.min_ones <= 4'd9 &&
        time_bus.sec_tens <= 4'd5 && time_bus.min_tens <= 4'd5);

endmodule

`default_nettype wire

// File: logic/display_scan.sv
`timescale 1ns/1ps
`default_nettype none
`include "stopwatch_macros.svh"

module display_scan #(
    parameter int SCAN_DIV = `STOPWATCH_SCAN_DIV
) (
    input  logic       clk,
    input  logic       rst_n,
    time_if.consumer   time_bus,
    output logic [3:0] an,
    output logic [6:0] seg
);
    import stopwatch_pkg::*;

    localparam int SCAN_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(SCAN_DIV - 1);

    logic [SCAN_W-1:0] dwell;
    logic [1:0]        sel;
    bcd_t              digit;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dwell <= '0;
            sel   <= 2'd0;
        end
        else if (dwell == SCAN_LAST)
        begin
            dwell <= '0;
            sel   <= sel + 2'd1;
        end
        else
        begin
            dwell <= dwell + 1'b1;
        end
    end

    // Order sec_ones, sec_tens, min_ones, min_tens
    always_comb
    begin
        case (sel)
            2'd0:    digit = time_bus.sec_ones;
            2'd1:    digit = time_bus.sec_tens;
            2'd2:    digit = time_bus.min_ones;
            default: digit = time_bus.min_tens;
        endcase
    end

    assign an = ~(4'b0001 << sel);

    // seg[6] is segment a, seg[0] is segment g, low lights it
    always_comb
    begin
        case (digit)
            4'd0:    seg = 7'b0000001;
            4'd1:    seg = 7'b1001111;
            4'd2:    seg = 7'b0010010;
            4'd3:    seg = 7'b0000110;
            4'd4:    seg = 7'b1001100;
            4'd5:    seg = 7'b0100100;
            4'd6:    seg = 7'b0100000;
            4'd7:    seg = 7'b0001111;
            4'd8:    seg = 7'b0000000;
            4'd9:    seg = 7'b0000100;
            default: seg = 7'b1111111;
        endcase
    end

    // The lit digit always has a pattern
    a_digit_valid: assert property (@(posedge clk) disable iff (!rst_n)
        digit <= 4'd9);

endmodule

`default_nettype wire

// File: logic/stopwatch_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "stopwatch_macros.svh"

module stopwatch_top #(
    parameter int TICK_DIV = `STOPWATCH_TICK_DIV,
    parameter int SCAN_DIV = `STOPWATCH_SCAN_DIV
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 hour_set,
    input  logic                 pb_stop,
    input  logic                 pb_pause,
    output stopwatch_pkg::mode_t mode,
    output stopwatch_pkg::bcd_t  min_tens,
    output stopwatch_pkg::bcd_t  min_ones,
    output stopwatch_pkg::bcd_t  sec_tens,
    output stopwatch_pkg::bcd_t  sec_ones,
    output logic [3:0]           an,
    output logic [6:0]           seg
);

    logic hour_set_level;
    logic stop_press;
    logic pause_press;

    time_if time_bus ();

    button_conditioner button_conditioner_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .hour_set       (hour_set),
        .pb_stop        (pb_stop),
        .pb_pause       (pb_pause),
        .hour_set_level (hour_set_level),
        .stop_press     (stop_press),
        .pause_press    (pause_press)
    );

    mode_fsm mode_fsm_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .hour_set_level (hour_set_level),
        .stop_press     (stop_press),
        .pause_press    (pause_press),
        .mode           (mode)
    );

    time_counter #(.TICK_DIV(TICK_DIV)) time_counter_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .mode     (mode),
        .time_bus (time_bus.producer)
    );

    display_scan #(.SCAN_DIV(SCAN_DIV)) display_scan_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .time_bus (time_bus.consumer),
        .an       (an),
        .seg      (seg)
    );

    assign min_tens = time_bus.min_tens;
    assign min_ones = time_bus.min_ones;
    assign sec_tens = time_bus.sec_tens;
    assign sec_ones = time_bus.sec_ones;

endmodule

`default_nettype wire

// File: dv/stopwatch_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "stopwatch_macros.svh"

module stopwatch_tb;
    import stopwatch_pkg::*;

    localparam int TICK_DIV        = `STOPWATCH_TICK_DIV;
    localparam int RESET_CYCLES    = 5;
    localparam int PRESS_CYCLES    = 2;
    localparam int PRESS_LATENCY   = 4;
    localparam int MODE_WAIT       = 8;
    localparam int DISPLAY_SAMPLES = 40;
    localparam int NUM_ROWS        = 18;

    localparam logic [2:0] ACT_IDLE    = 3'd0;
    localparam logic [2:0] ACT_STOP    = 3'd1;
    localparam logic [2:0] ACT_PAUSE   = 3'd2;
    localparam logic [2:0] ACT_HOUR_HI = 3'd3;
    localparam logic [2:0] ACT_HOUR_LO = 3'd4;

    typedef struct packed {
        logic [2:0] action;
        logic [7:0] ticks;
        mode_t      mode;
        bcd_t       min_tens;
        bcd_t       min_ones;
        bcd_t       sec_tens;
        bcd_t       sec_ones;
    } row_t;

    logic       clk;
    logic       rst_n;
    logic       hour_set;
    logic       pb_stop;
    logic       pb_pause;
    mode_t      mode;
    bcd_t       min_tens;
    bcd_t       min_ones;
    bcd_t       sec_tens;
    bcd_t       sec_ones;
    logic [3:0] an;
    logic [6:0] seg;

    row_t   rows [NUM_ROWS];
    integer seed;
    int     cycle_count = 0;
    int     cycle_limit = 0;
    int     row_idx;
    int     wait_cycles;
    int     gap;

    stopwatch_top #(.TICK_DIV(TICK_DIV)) stopwatch_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .hour_set (hour_set),
        .pb_stop  (pb_stop),
        .pb_pause (pb_pause),
        .mode     (mode),
        .min_tens (min_tens),
        .min_ones (min_ones),
        .sec_tens (sec_tens),
        .sec_ones (sec_ones),
        .an       (an),
        .seg      (seg)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit)
        begin
            $display("Timeout: the run went past %0d clock cycles", cycle_limit);
            abort_run();
        end
    end

    task abort_run();
        $display("Done: errors found");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_mode(input string name, input mode_t got, input mode_t exp);
        if (got !== exp)
        begin
            $display("FAILED time %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
            abort_run();
        end
    endtask

    task automatic check_digit(input string name, input bcd_t got, input bcd_t exp);
        if (got !== exp)
        begin
            $display("FAILED time %0t: %s is %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_segments(input string name, input logic [6:0] got,
                                  input logic [6:0] exp);
        if (got !== exp)
        begin
            $display("FAILED time %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_anodes(input string name, input logic [3:0] got,
                                input logic [3:0] exp);
        if (got !== exp)
        begin
            $display("FAILED time %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Active low, a on bit 6 down to g on bit 0
    function automatic logic [6:0] seg_pattern(input bcd_t d);
        logic [6:0] p;
        case (d)
            4'd0:    p = 7'b0000001;
            4'd1:    p = 7'b1001111;
            4'd2:    p = 7'b0010010;
            4'd3:    p = 7'b0000110;
            4'd4:    p = 7'b1001100;
            4'd5:    p = 7'b0100100;
            4'd6:    p = 7'b0100000;
            4'd7:    p = 7'b0001111;
            4'd8:    p = 7'b0000000;
            4'd9:    p = 7'b0000100;
            default: p = 7'b1111111;
        endcase
        return p;
    endfunction

    task automatic set_row(input int idx, input logic [2:0] action, input int ticks);
        rows[idx]        = '0;
        rows[idx].action = action;
        rows[idx].ticks  = 8'(ticks);
    endtask

    task automatic load_table();
        set_row(0, ACT_PAUSE, 1);
        // Count, carry into minutes, freeze and resume
        set_row(1, ACT_STOP, 5);
        set_row(2, ACT_IDLE, 55);
        set_row(3, ACT_IDLE, 7);
        set_row(4, ACT_PAUSE, 3);
        set_row(5, ACT_PAUSE, 4);
        // Set minutes from RUNNING, through the 59 wrap
        set_row(6, ACT_HOUR_HI, 3);
        set_row(7, ACT_IDLE, 55);
        set_row(8, ACT_IDLE, 2);
        set_row(9, ACT_HOUR_LO, 2);
        set_row(10, ACT_STOP, 1);
        set_row(11, ACT_STOP, 12);
        set_row(12, ACT_STOP, 2);
        set_row(13, ACT_HOUR_HI, 1);
        set_row(14, ACT_HOUR_LO, 1);
        set_row(15, ACT_PAUSE, 2);
        set_row(16, ACT_STOP, 1);
        set_row(17, ACT_STOP, 3);
    endtask

    // Ticks of one mode applied to the minutes:seconds count
    task automatic advance_time(input mode_t m, input int ticks,
                                inout int mn, inout int sec);
        int total;
        case (m)
            MODE_RUNNING:
            begin
                total = (mn * 60 + sec + ticks) % 3600;
                mn    = total / 60;
                sec   = total % 60;
            end
            MODE_SETTING: mn = (mn + ticks) % 60;
            MODE_STOPPED:
            begin
                mn  = 0;
                sec = 0;
            end
            default: ;
        endcase
    endtask

    // Reference model of the mode table and the minutes:seconds count
    task automatic build_expected();
        mode_t m;
        mode_t nm;
        int    i;
        int    extra;
        int    mn;
        int    sec;
        m   = MODE_STOPPED;
        mn  = 0;
        sec = 0;
        for (i = 0; i < NUM_ROWS; i++)
        begin
            nm = m;
            case (rows[i].action)
                ACT_STOP:
                begin
                    if (m == MODE_STOPPED)
                        nm = MODE_RUNNING;
                    else if (m == MODE_PAUSED || m == MODE_RUNNING)
                        nm = MODE_STOPPED;
                end
                ACT_PAUSE:
                begin
                    if (m == MODE_PAUSED)
                        nm = MODE_RUNNING;
                    else if (m == MODE_RUNNING)
                        nm = MODE_PAUSED;
                end
                ACT_HOUR_HI: nm = MODE_SETTING;
                ACT_HOUR_LO:
                begin
                    if (m == MODE_SETTING)
                        nm = MODE_PAUSED;
                end
                default: ;
            endcase
            // Old mode keeps counting until the input reaches the mode register
            extra = (nm != m) ? PRESS_LATENCY / TICK_DIV : 0;
            advance_time(m, extra, mn, sec);
            m = nm;
            advance_time(m, rows[i].ticks, mn, sec);
            rows[i].mode     = m;
            rows[i].min_tens = bcd_t'(mn / 10);
            rows[i].min_ones = bcd_t'(mn % 10);
            rows[i].sec_tens = bcd_t'(sec / 10);
            rows[i].sec_ones = bcd_t'(sec % 10);
        end
    endtask

    task automatic apply_action(input logic [2:0] action);
        case (action)
            ACT_STOP:
            begin
                pb_stop = 1'b1;
                repeat (PRESS_CYCLES) @(negedge clk);
                pb_stop = 1'b0;
            end
            ACT_PAUSE:
            begin
                pb_pause = 1'b1;
                repeat (PRESS_CYCLES) @(negedge clk);
                pb_pause = 1'b0;
            end
            ACT_HOUR_HI: hour_set = 1'b1;
            ACT_HOUR_LO: hour_set = 1'b0;
            default: ;
        endcase
    endtask

    task automatic wait_for_mode(input mode_t exp);
        int waited;
        waited = 0;
        while (mode !== exp && waited < MODE_WAIT)
        begin
            @(negedge clk);
            waited++;
        end
        check_mode("mode", mode, exp);
    endtask

    task automatic check_row(input row_t r);
        check_mode("mode", mode, r.mode);
        check_digit("min_tens", min_tens, r.min_tens);
        check_digit("min_ones", min_ones, r.min_ones);
        check_digit("sec_tens", sec_tens, r.sec_tens);
        check_digit("sec_ones", sec_ones, r.sec_ones);
    endtask

    task automatic check_display(input int samples);
        int   n;
        bcd_t lit;
        for (n = 0; n < samples; n++)
        begin
            @(negedge clk);
            if (!$onehot(~an))
            begin
                $display("Display fault at time %0t: anodes %b do not light exactly one digit",
                         $time, an);
                abort_run();
            end
            else
            begin
                case (an)
                    4'b1110: lit = sec_ones;
                    4'b1101: lit = sec_tens;
                    4'b1011: lit = min_ones;
                    default: lit = min_tens;
                endcase
                check_segments("seg", seg, seg_pattern(lit));
            end
        end
    endtask

    initial
    begin
        rst_n    = 1'b0;
        hour_set = 1'b0;
        pb_stop  = 1'b0;
        pb_pause = 1'b0;
        seed     = 32'h4a8;
        load_table();
        build_expected();

        cycle_limit = DISPLAY_SAMPLES;
        for (row_idx = 0; row_idx < NUM_ROWS; row_idx++)
        begin
            cycle_limit += rows[row_idx].ticks * TICK_DIV + PRESS_CYCLES + MODE_WAIT + 3;
        end
        cycle_limit = 2 * cycle_limit + RESET_CYCLES + 2;

        repeat (RESET_CYCLES) @(negedge clk);
        check_mode("mode", mode, MODE_STOPPED);
        check_digit("sec_ones", sec_ones, 4'd0);
        check_digit("sec_tens", sec_tens, 4'd0);
        check_digit("min_ones", min_ones, 4'd0);
        check_digit("min_tens", min_tens, 4'd0);
        check_anodes("an", an, 4'b1110);
        check_segments("seg", seg, seg_pattern(4'd0));
        rst_n = 1'b1;
        @(negedge clk);

        for (row_idx = 0; row_idx < NUM_ROWS; row_idx++)
        begin
            apply_action(rows[row_idx].action);
            wait_for_mode(rows[row_idx].mode);
            wait_cycles = rows[row_idx].ticks * TICK_DIV;
            repeat (wait_cycles) @(negedge clk);
            check_row(rows[row_idx]);
            // Digits cannot move here, so a gap is harmless
            if (rows[row_idx].mode == MODE_PAUSED || rows[row_idx].mode == MODE_STOPPED)
            begin
                gap = {$random(seed)} % 4;
                repeat (gap) @(negedge clk);
            end
        end

        check_display(DISPLAY_SAMPLES);
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
logic/stopwatch_pkg.sv
logic/time_if.sv
logic/button_conditioner.sv
logic/mode_fsm.sv
logic/time_counter.sv
logic/display_scan.sv
logic/stopwatch_top.sv
dv/stopwatch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the stopwatch testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f filelist.f --top-module stopwatch_tb \
    -o stopwatch_sim \
    && ./obj_dir/stopwatch_sim > sim.log 2>&1 \
    || echo "Build or simulation exited with an error status"

cat sim.log 2>/dev/null

grep -q "^Done: no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
